//--- Makefile
VERILATOR  := verilator
TOP        := mem_test_tb
FILELIST   := mem_test_top.f
MDIR       := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert --Mdir $(MDIR)

.PHONY: all lint sim clean

all: sim

# Static checks on the whole project
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(MDIR)/V$(TOP)

clean:
	rm -rf $(MDIR)

//--- design/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram
    import mem_cfg_pkg::*;
    import mem_test_pkg::*;
(
    input  logic    clk,
    input  ram_wr_t wr,
    input  ram_rd_t rd,
    output data_t   rd_data
);

    (* ram_style = "block" *) data_t mem [0:MAX_ADDR];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Output holds while no read is requested
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

    // Write and read passes never overlap on one address
    a_no_rw_collision: assert property (
        @(posedge clk) !(wr.en && rd.en && (wr.addr == rd.addr))
    );

endmodule

//--- design/error_reporter.sv
`timescale 1ns/1ps

module error_reporter
    import mem_cfg_pkg::*;
    import mem_test_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  report_t    report,
    input  logic       report_valid,
    output logic       report_ready,
    output logic [7:0] tx_data,
    output logic       tx_data_ready,
    input  logic       tx_data_accepted
);

    report_t   rec;
    logic      full;
    byte_idx_t idx;
    byte_idx_t last_idx;
    data_t     addr_ext;

    assign report_ready  = !full;
    assign tx_data_ready = full;

    assign last_idx = (rec.kind == REC_ERROR) ? byte_idx_t'(ERROR_BYTES - 1)
                                              : byte_idx_t'(LOOP_BYTES - 1);

    // High byte first
    always_comb begin
        addr_ext = data_t'(rec.addr);
        tx_data  = 8'h00;
        if (rec.kind == REC_ERROR) begin
            case (idx)
                3'd0:    tx_data = TAG_ERROR;
                3'd1:    tx_data = addr_ext[15:8];
                3'd2:    tx_data = addr_ext[7:0];
                3'd3:    tx_data = rec.expected[15:8];
                3'd4:    tx_data = rec.expected[7:0];
                3'd5:    tx_data = rec.actual[15:8];
                default: tx_data = rec.actual[7:0];
            endcase
        end else begin
            case (idx)
                3'd0:    tx_data = TAG_LOOP;
                3'd1:    tx_data = rec.count[15:8];
                default: tx_data = rec.count[7:0];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
            idx  <= '0;
        end else if (!full) begin
            if (report_valid) begin
                full <= 1'b1;
                idx  <= '0;
            end
        end else if (tx_data_accepted) begin
            if (idx == last_idx) begin
                full <= 1'b0;
                idx  <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (report_valid && report_ready) begin
            rec <= report;
        end
    end

    a_tx_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_data_ready && !tx_data_accepted |=> tx_data_ready && $stable(tx_data)
    );

endmodule

//--- design/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // Memory geometry
    localparam int ADDR_W    = 10;
    localparam int DATA_W    = 16;
    localparam int COUNT_W   = 16;
    localparam int MAX_ADDR  = 1023;

    // Test loop stride and the last stepped address
    localparam int ADDR_STEP = 2;
    localparam int LAST_ADDR = MAX_ADDR + 1 - ADDR_STEP;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;

    // Saturates at all ones
    typedef logic [COUNT_W-1:0] count_t;

endpackage

//--- design/mem_test_pkg.sv
package mem_test_pkg;

    import mem_cfg_pkg::*;

    // Test opcode
    typedef enum logic [1:0] {
        PAT_ADDR,
        PAT_INV_ADDR,
        PAT_CHECKER,
        PAT_WALK
    } pattern_e;

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        READ,
        REPORT_WAIT,
        SUMMARY
    } tester_state_e;

    typedef enum logic {
        REC_ERROR,
        REC_LOOP
    } rec_kind_e;

    // Mask of zero means no fault
    typedef struct packed {
        pattern_e pattern;
        addr_t    inject_addr;
        data_t    inject_mask;
    } test_cmd_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } ram_wr_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } ram_rd_t;

    typedef struct packed {
        rec_kind_e kind;
        addr_t     addr;
        data_t     expected;
        data_t     actual;
        count_t    count;
    } report_t;

    // First byte of each record
    localparam logic [7:0] TAG_ERROR = 8'h45;
    localparam logic [7:0] TAG_LOOP  = 8'h4C;

    localparam int ERROR_BYTES = 7;
    localparam int LOOP_BYTES  = 3;

    typedef logic [2:0] byte_idx_t;

endpackage

//--- design/mem_test_top.sv
`timescale 1ns/1ps

module mem_test_top
    import mem_cfg_pkg::*;
    import mem_test_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  test_cmd_t  cmd,
    input  logic       start,
    output logic       busy,
    output logic [7:0] tx_data,
    output logic       tx_data_ready,
    input  logic       tx_data_accepted
);

    ram_wr_t wr;
    ram_rd_t rd;
    data_t   rd_data;
    report_t report;
    logic    report_valid;
    logic    report_ready;

    pattern_tester tester (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .start        (start),
        .busy         (busy),
        .wr           (wr),
        .rd           (rd),
        .rd_data      (rd_data),
        .report       (report),
        .report_valid (report_valid),
        .report_ready (report_ready)
    );

    dual_port_ram ram (
        .clk     (clk),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

    error_reporter reporter (
        .clk              (clk),
        .rst              (rst),
        .report           (report),
        .report_valid     (report_valid),
        .report_ready     (report_ready),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted)
    );

endmodule

//--- design/pattern_tester.sv
`timescale 1ns/1ps

module pattern_tester
    import mem_cfg_pkg::*;
    import mem_test_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  test_cmd_t cmd,
    input  logic      start,
    output logic      busy,
    output ram_wr_t   wr,
    output ram_rd_t   rd,
    input  data_t     rd_data,
    output report_t   report,
    output logic      report_valid,
    input  logic      report_ready
);

    tester_state_e state;
    test_cmd_t     cmd_q;
    addr_t         addr;
    logic          issue_done;
    logic          pend;
    addr_t         pend_addr;
    logic          hold_valid;
    addr_t         hold_addr;
    data_t         hold_data;
    count_t        err_count;
    count_t        count_next;

    logic          last_addr;
    logic          cmp_valid;
    addr_t         cmp_addr;
    data_t         cmp_data;
    data_t         cmp_exp;
    logic          mismatch;

    // Shared by the write data and the expected data
    function automatic data_t pattern_word(pattern_e pat, addr_t a);
        case (pat)
            PAT_ADDR:     return data_t'(a);
            PAT_INV_ADDR: return ~data_t'(a);
            PAT_CHECKER:  return a[1] ? 16'h5555 : 16'hAAAA;
            default:      return data_t'(1) << ((a / ADDR_STEP) % DATA_W);
        endcase
    endfunction

    assign busy      = (state != IDLE);
    assign last_addr = (addr == addr_t'(LAST_ADDR));

    // Fault goes into the written word only
    always_comb begin
        wr.en   = (state == WRITE);
        wr.addr = addr;
        wr.data = pattern_word(cmd_q.pattern, addr);
        if (addr == cmd_q.inject_addr) begin
            wr.data = wr.data ^ cmd_q.inject_mask;
        end
    end

    assign rd.en   = (state == READ) && !issue_done;
    assign rd.addr = addr;

    // Held word goes first after a stall
    assign cmp_valid = hold_valid || pend;
    assign cmp_addr  = hold_valid ? hold_addr : pend_addr;
    assign cmp_data  = hold_valid ? hold_data : rd_data;
    assign cmp_exp   = pattern_word(cmd_q.pattern, cmp_addr);
    assign mismatch  = (state == READ) && cmp_valid && (cmp_data != cmp_exp);

    assign count_next = (err_count == '1) ? err_count : err_count + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            addr         <= '0;
            issue_done   <= 1'b0;
            pend         <= 1'b0;
            hold_valid   <= 1'b0;
            err_count    <= '0;
            report_valid <= 1'b0;
        end else begin
            pend <= rd.en;
            case (state)
                IDLE: begin
                    if (start) begin
                        addr       <= '0;
                        issue_done <= 1'b0;
                        hold_valid <= 1'b0;
                        err_count  <= '0;
                        state      <= WRITE;
                    end
                end
                WRITE: begin
                    if (last_addr) begin
                        addr  <= '0;
                        state <= READ;
                    end else begin
                        addr <= addr + addr_t'(ADDR_STEP);
                    end
                end
                READ: begin
                    if (rd.en) begin
                        if (last_addr) begin
                            issue_done <= 1'b1;
                        end else begin
                            addr <= addr + addr_t'(ADDR_STEP);
                        end
                    end
                    hold_valid <= 1'b0;
                    if (mismatch) begin
                        err_count    <= count_next;
                        report_valid <= 1'b1;
                        state        <= REPORT_WAIT;
                    end else if (issue_done) begin
                        state <= SUMMARY;
                    end
                end
                REPORT_WAIT: begin
                    // Word still in flight from the mismatch cycle
                    if (pend) begin
                        hold_valid <= 1'b1;
                    end
                    if (report_ready) begin
                        report_valid <= 1'b0;
                        state        <= READ;
                    end
                end
                SUMMARY: begin
                    if (!report_valid) begin
                        report_valid <= 1'b1;
                    end else if (report_ready) begin
                        report_valid <= 1'b0;
                        state        <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            cmd_q <= cmd;
        end
        if (rd.en) begin
            pend_addr <= addr;
        end
        if (state == REPORT_WAIT && pend) begin
            hold_addr <= pend_addr;
            hold_data <= rd_data;
        end
        if (mismatch) begin
            report <= '{kind: REC_ERROR, addr: cmp_addr, expected: cmp_exp,
                        actual: cmp_data, count: count_next};
        end else if (state == SUMMARY && !report_valid) begin
            report <= '{kind: REC_LOOP, addr: '0, expected: '0,
                        actual: '0, count: err_count};
        end
    end

    a_report_stable: assert property (
        @(posedge clk) disable iff (rst)
        report_valid && !report_ready |=> report_valid && $stable(report)
    );

    // Write pass never overlaps read or report activity
    a_write_pass_alone: assert property (
        @(posedge clk) disable iff (rst)
        wr.en |-> !pend && !hold_valid && !report_valid
    );

endmodule

//--- mem_test_top.f
design/mem_cfg_pkg.sv
design/mem_test_pkg.sv
design/dual_port_ram.sv
design/pattern_tester.sv
design/error_reporter.sv
design/mem_test_top.sv
verification/mem_test_tb.sv

//--- verification/mem_test_stim.txt
# opcode inject_addr inject_mask gap
# hex    hex         hex         decimal cycles before each byte is accepted
0 000 0000 0
1 000 0000 0
2 000 0000 0
3 000 0000 0
0 024 0001 0
1 3fe 8000 0
2 102 ffff 1
3 05a 00f0 7
0 001 0001 0
2 3ff 1234 1
1 156 5a5a 0
1 156 5a5a 1
1 156 5a5a 7
3 000 0000 7
0 000 0000 1
3 01e 0100 0
2 000 0003 0

//--- verification/mem_test_tb.sv
`timescale 1ns/1ps

module mem_test_tb
    import mem_cfg_pkg::*;
    import mem_test_pkg::*;
;

    // Write pass, read pass, drain and loop record
    localparam int BUSY_CYCLES = 2 * (MAX_ADDR + 1) / ADDR_STEP + 3;
    localparam int TEST_BASE   = 1100;
    localparam int MAX_BYTES   = ERROR_BYTES + LOOP_BYTES;

    logic       clk;
    logic       rst;
    test_cmd_t  cmd;
    logic       start;
    logic       busy;
    logic [7:0] tx_data;
    logic       tx_data_ready;
    logic       tx_data_accepted;

    logic [1:0] op_q[$];
    addr_t      ia_q[$];
    data_t      mask_q[$];
    int         gap_q[$];
    logic [7:0] exp_bytes[$];
    int         exp_errors;
    int         cycles;
    int         cycle_limit;

    mem_test_top dut (
        .clk              (clk),
        .rst              (rst),
        .cmd              (cmd),
        .start            (start),
        .busy             (busy),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted)
    );

    always #10 clk = ~clk;

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles, a test never finished", cycles));
        end
    end

    // Pattern rules, word for a given address
    function automatic data_t expected_word(logic [1:0] op, addr_t a);
        if (op == PAT_ADDR) begin
            return {6'b0, a};
        end else if (op == PAT_INV_ADDR) begin
            return ~{6'b0, a};
        end else if (op == PAT_CHECKER) begin
            return a[1] ? 16'h5555 : 16'hAAAA;
        end
        return 16'h0001 << a[4:1];
    endfunction

    task automatic build_expected(logic [1:0] op, addr_t ia, data_t mask);
        data_t good;
        good = expected_word(op, ia);
        exp_bytes.delete();
        exp_errors = 0;
        // Odd addresses are never written
        if (mask != '0 && ia[0] == 1'b0) begin
            exp_errors = 1;
            exp_bytes.push_back(TAG_ERROR);
            exp_bytes.push_back({6'b0, ia[9:8]});
            exp_bytes.push_back(ia[7:0]);
            exp_bytes.push_back(good[15:8]);
            exp_bytes.push_back(good[7:0]);
            exp_bytes.push_back(good[15:8] ^ mask[15:8]);
            exp_bytes.push_back(good[7:0] ^ mask[7:0]);
        end
        exp_bytes.push_back(TAG_LOOP);
        exp_bytes.push_back(8'h00);
        exp_bytes.push_back(8'(exp_errors));
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          max_gap;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_ia;
        logic [31:0] f_mask;
        int          f_gap;
        max_gap = 0;
        fd = $fopen("verification/mem_test_stim.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file verification/mem_test_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %d", f_op, f_ia, f_mask, f_gap);
                    if (n == 4) begin
                        if (f_op > 3 || f_ia > MAX_ADDR || f_mask > 32'hFFFF || f_gap < 0) begin
                            fail_run($sformatf("Stimulus line out of range: %s", line));
                        end
                        op_q.push_back(f_op[1:0]);
                        ia_q.push_back(addr_t'(f_ia));
                        mask_q.push_back(data_t'(f_mask));
                        gap_q.push_back(f_gap);
                        if (f_gap > max_gap) begin
                            max_gap = f_gap;
                        end
                    end
                end
            end
            $fclose(fd);
            if (op_q.size() == 0) begin
                fail_run("The stimulus file holds no tests");
            end
            cycle_limit = op_q.size() * (TEST_BASE + MAX_BYTES * 8 * (max_gap + 1));
        end
    endtask

    task automatic run_test(int i);
        test_cmd_t  c;
        logic [7:0] got_bytes[$];
        logic [7:0] held;
        int         gap;
        int         cyc;
        int         wait_cnt;
        int         busy_cycles;
        logic       busy_fell;
        logic       done;
        gap           = gap_q[i];
        c.pattern     = pattern_e'(op_q[i]);
        c.inject_addr = ia_q[i];
        c.inject_mask = mask_q[i];
        build_expected(op_q[i], ia_q[i], mask_q[i]);
        cyc         = 0;
        wait_cnt    = 0;
        busy_cycles = 0;
        busy_fell   = 1'b0;
        done        = 1'b0;
        held        = '0;
        @(negedge clk);
        cmd   = c;
        start = 1'b1;
        while (!done) begin
            @(negedge clk);
            cyc   = cyc + 1;
            start = 1'b0;
            cmd   = c;
            if (cyc == 5) begin
                // Must not start a second test
                start = 1'b1;
                cmd   = '{pattern: PAT_WALK, inject_addr: '0, inject_mask: 16'hFFFF};
            end
            if (cyc == 1) begin
                check("busy", 32'(busy), 32'd1);
            end
            if (busy) begin
                if (busy_fell) begin
                    check("busy", 32'(busy), 32'd0);
                end
                busy_cycles = busy_cycles + 1;
            end else begin
                busy_fell = 1'b1;
            end
            // Byte receiver with accept gap
            if (tx_data_ready) begin
                if (wait_cnt > 0) begin
                    check("tx_data", 32'(tx_data), 32'(held));
                end
                if (wait_cnt < gap) begin
                    held             = tx_data;
                    wait_cnt         = wait_cnt + 1;
                    tx_data_accepted = 1'b0;
                end else begin
                    got_bytes.push_back(tx_data);
                    wait_cnt         = 0;
                    tx_data_accepted = 1'b1;
                end
            end else begin
                if (wait_cnt > 0) begin
                    check("tx_data_ready", 32'(tx_data_ready), 32'd1);
                end
                tx_data_accepted = 1'b0;
            end
            done = !busy && !tx_data_ready && (got_bytes.size() >= exp_bytes.size());
        end
        check("byte count", 32'(got_bytes.size()), 32'(exp_bytes.size()));
        foreach (exp_bytes[k]) begin
            check($sformatf("tx_data[%0d]", k), 32'(got_bytes[k]), 32'(exp_bytes[k]));
        end
        if (gap == 0 && exp_errors == 0) begin
            check("busy cycles", 32'(busy_cycles), 32'(BUSY_CYCLES));
        end
    endtask

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        cmd              = '0;
        start            = 1'b0;
        tx_data_accepted = 1'b0;
        cycles           = 0;
        cycle_limit      = TEST_BASE;
        load_stimulus();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("busy", 32'(busy), 32'd0);
        check("tx_data_ready", 32'(tx_data_ready), 32'd0);
        for (int i = 0; i < op_q.size(); i++) begin
            run_test(i);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
